// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tester_top_tb
FILELIST   ?= tester_top.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps

SIM       := $(BUILD_DIR)/V$(TOP)
PASS_TEXT := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the exit status comes from the search for the pass line
run: build
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^$(PASS_TEXT)$$'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: source/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
	input  logic              cpuclk,
	input  logic              f_reset,
	input  bus_pkg::bus_req_t req,
	output bus_pkg::dec_req_t dec
);

	bus_pkg::region_e region;

	// map lookup
	always_comb begin
		region = bus_pkg::region_none;
		if (req.adr[bus_pkg::addr_w-1:bus_pkg::ram_depth_log2] ==
				bus_pkg::sysram_base[bus_pkg::addr_w-1:bus_pkg::ram_depth_log2])
			region = bus_pkg::region_sysram;
		else if (req.adr == bus_pkg::led0_adr)
			region = bus_pkg::region_led0;
		else if (req.adr == bus_pkg::led1_adr)
			region = bus_pkg::region_led1;
		else if (req.adr == bus_pkg::sw0_adr)
			region = bus_pkg::region_sw0;
		else if (req.adr == bus_pkg::sw1_adr)
			region = bus_pkg::region_sw1;
		else if (req.adr[bus_pkg::addr_w-1:2] == bus_pkg::atom_base[bus_pkg::addr_w-1:2])
			region = bus_pkg::region_atom; // 0xff10-0xff13
		else if (req.adr == bus_pkg::route_adr)
			region = bus_pkg::region_route;
		else if (req.adr[bus_pkg::addr_w-1:2] == bus_pkg::pa_base[bus_pkg::addr_w-1:2])
			region = bus_pkg::region_pa; // 0xff40-0xff43
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			dec.region <= bus_pkg::region_none;
			dec.offset <= '0;
			dec.wdata  <= '0;
			dec.rd     <= 1'b0;
			dec.wr     <= 1'b0;
		end else begin
			dec.region <= region;
			dec.offset <= req.adr[bus_pkg::ram_depth_log2-1:0];
			dec.wdata  <= req.wdata;
			dec.rd     <= req.rd;
			dec.wr     <= req.wr;
		end
	end

endmodule

// File: source/bus_pkg.sv
package bus_pkg;

	localparam int addr_w         = 16;
	localparam int data_w         = 8;
	localparam int ram_depth_log2 = 12; // 4096 bytes

	// cpu memory map
	localparam logic [addr_w-1:0] sysram_base = 16'h0000; // 0x0000-0x0fff
	localparam logic [addr_w-1:0] led0_adr    = 16'hff00;
	localparam logic [addr_w-1:0] led1_adr    = 16'hff01;
	localparam logic [addr_w-1:0] sw0_adr     = 16'hff02;
	localparam logic [addr_w-1:0] sw1_adr     = 16'hff03;
	localparam logic [addr_w-1:0] atom_base   = 16'hff10; // 4 bytes
	localparam logic [addr_w-1:0] route_adr   = 16'hff14;
	localparam logic [addr_w-1:0] pa_base     = 16'hff40; // 4 bytes

	// region_none must stay zero, decoder reset relies on it
	typedef enum logic [3:0] {
		region_none   = 4'd0,
		region_sysram = 4'd1,
		region_led0   = 4'd2,
		region_led1   = 4'd3,
		region_sw0    = 4'd4,
		region_sw1    = 4'd5,
		region_atom   = 4'd6,
		region_route  = 4'd7,
		region_pa     = 4'd8
	} region_e;

	typedef struct packed {
		logic [addr_w-1:0] adr;
		logic [data_w-1:0] wdata;
		logic              rd;
		logic              wr;
	} bus_req_t;

	typedef struct packed {
		region_e                   region;
		logic [ram_depth_log2-1:0] offset; // low address bits
		logic [data_w-1:0]         wdata;
		logic                      rd;
		logic                      wr;
	} dec_req_t;

endpackage

// File: source/io_pkg.sv
package io_pkg;

	localparam int led_w      = 16;
	localparam int sw_w       = 16;
	localparam int atom_w     = 32;
	localparam int num_routes = 4;
	localparam int pa_w       = 8;

	// port A register select, low two address bits
	typedef enum logic [1:0] {
		pa_set        = 2'd0,
		pa_reset      = 2'd1,
		pa_trig_set   = 2'd2,
		pa_trig_reset = 2'd3
	} pa_reg_e;

	// value seen on the bus when nothing drives it
	localparam logic [7:0] idle_read = 8'hff;

endpackage

// File: source/io_regs.sv
`timescale 1ns/1ps

module io_regs (
	input  logic                        cpuclk,
	input  logic                        f_reset,
	input  bus_pkg::dec_req_t           dec,
	input  logic [bus_pkg::data_w-1:0]  ram_rdata,
	input  logic [io_pkg::sw_w-1:0]     sw,
	input  logic [io_pkg::pa_w-1:0]     pa_in,
	output logic [bus_pkg::data_w-1:0]  rdata,
	output logic                        rdata_valid,
	output logic [io_pkg::led_w-1:0]    led,
	output logic [io_pkg::pa_w-1:0]     pa_out
);

	logic [io_pkg::atom_w-1:0]     atom;
	logic [io_pkg::num_routes-1:0] route;
	logic [io_pkg::num_routes-1:0] trig_set;
	logic [io_pkg::num_routes-1:0] trig_reset;
	logic [io_pkg::pa_w-1:0]       set_mask;
	logic [io_pkg::pa_w-1:0]       reset_mask;
	logic [io_pkg::pa_w-1:0]       set_eff;
	logic [io_pkg::pa_w-1:0]       reset_eff;
	logic                          pa_wr;
	logic                          pa_wr_q;
	logic                          pa_trigger;
	io_pkg::pa_reg_e               pa_sel;
	logic [bus_pkg::data_w-1:0]    rd_next;
	logic [bus_pkg::data_w-1:0]    rdata_q;
	logic                          sel_ram;

	assign pa_sel = io_pkg::pa_reg_e'(dec.offset[1:0]);
	assign pa_wr  = dec.wr && (dec.region == bus_pkg::region_pa);

	// only the first cycle of a port A write burst counts
	assign pa_trigger = pa_wr && !pa_wr_q;

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			led   <= '0;
			atom  <= '0;
			route <= '0;
		end else if (dec.wr) begin
			case (dec.region)
			bus_pkg::region_led0:  led[7:0]  <= dec.wdata;
			bus_pkg::region_led1:  led[15:8] <= dec.wdata;
			bus_pkg::region_atom:  atom[{dec.offset[1:0], 3'b000} +: 8] <= dec.wdata;
			bus_pkg::region_route: route <= atom[io_pkg::num_routes-1:0];
			default: ;
			endcase
		end
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			pa_wr_q    <= 1'b0;
			set_mask   <= '0;
			reset_mask <= '0;
			trig_set   <= '0;
			trig_reset <= '0;
		end else begin
			pa_wr_q    <= pa_wr;
			set_mask   <= '0; // masks live for one cycle
			reset_mask <= '0;
			if (pa_trigger) begin
				case (pa_sel)
				io_pkg::pa_set:   set_mask   <= dec.wdata;
				io_pkg::pa_reset: reset_mask <= dec.wdata;
				io_pkg::pa_trig_set:
					if (dec.wdata == 8'd1)
						trig_set <= atom[io_pkg::num_routes-1:0];
				io_pkg::pa_trig_reset:
					if (dec.wdata == 8'd1)
						trig_reset <= atom[io_pkg::num_routes-1:0];
				endcase
			end
		end
	end

	// routed triggers hold bit 0 for as long as they match
	always_comb begin
		set_eff      = set_mask;
		reset_eff    = reset_mask;
		set_eff[0]   = set_mask[0] | (|(trig_set & route));
		reset_eff[0] = reset_mask[0] | (|(trig_reset & route));
	end

	always_ff @(posedge cpuclk) begin
		if (f_reset)
			pa_out <= '0;
		else
			pa_out <= (pa_out | set_eff) & ~reset_eff; // reset wins
	end

	always_comb begin
		rd_next = io_pkg::idle_read;
		case (dec.region)
		bus_pkg::region_led0: rd_next = led[7:0];
		bus_pkg::region_led1: rd_next = led[15:8];
		bus_pkg::region_sw0:  rd_next = sw[7:0];
		bus_pkg::region_sw1:  rd_next = sw[15:8];
		bus_pkg::region_atom: rd_next = atom[{dec.offset[1:0], 3'b000} +: 8];
		bus_pkg::region_pa:
			if (dec.offset[1:0] == 2'd0)
				rd_next = pa_out;
			else if (dec.offset[1:0] == 2'd1)
				rd_next = pa_in;
		default: ;
		endcase
	end

	// ram data arrives on the same edge, so it is picked after the register
	always_ff @(posedge cpuclk) begin
		if (f_reset) begin
			rdata_q     <= io_pkg::idle_read;
			sel_ram     <= 1'b0;
			rdata_valid <= 1'b0;
		end else begin
			rdata_q     <= dec.rd ? rd_next : io_pkg::idle_read;
			sel_ram     <= dec.rd && (dec.region == bus_pkg::region_sysram);
			rdata_valid <= dec.rd;
		end
	end

	assign rdata = sel_ram ? ram_rdata : rdata_q;

endmodule

// File: source/sys_ram.sv
`timescale 1ns/1ps

module sys_ram (
	input  logic                       cpuclk,
	input  bus_pkg::dec_req_t          dec,
	output logic [bus_pkg::data_w-1:0] ram_rdata
);

	localparam int depth = 1 << bus_pkg::ram_depth_log2;

	logic [bus_pkg::data_w-1:0] mem [0:depth-1];
	logic                       we;

	// jr -2 at reset vector, cpu spins in place
	initial begin
		mem[0] = 8'h18;
		mem[1] = 8'hfe;
	end

	assign we = dec.wr && (dec.region == bus_pkg::region_sysram);

	always @(posedge cpuclk) begin
		if (we)
			mem[dec.offset] <= dec.wdata;
	end

	// read every cycle, old data on a write to the same byte
	always_ff @(posedge cpuclk) begin
		ram_rdata <= mem[dec.offset];
	end

endmodule

// File: source/tester_top.sv
`timescale 1ns/1ps

module tester_top (
	input  logic                       cpuclk,
	input  logic                       f_reset,
	input  bus_pkg::bus_req_t          req,
	input  logic [io_pkg::sw_w-1:0]    sw,
	input  logic [io_pkg::pa_w-1:0]    pa_in,
	output logic [bus_pkg::data_w-1:0] rdata,
	output logic                       rdata_valid,
	output logic [io_pkg::led_w-1:0]   led,
	output logic [io_pkg::pa_w-1:0]    pa_out
);

	bus_pkg::dec_req_t          dec;
	logic [bus_pkg::data_w-1:0] ram_rdata;

	bus_decoder bus_decoder_inst (
		.cpuclk  (cpuclk),
		.f_reset (f_reset),
		.req     (req),
		.dec     (dec)
	);

	sys_ram sys_ram_inst (
		.cpuclk    (cpuclk),
		.dec       (dec),
		.ram_rdata (ram_rdata)
	);

	io_regs io_regs_inst (
		.cpuclk      (cpuclk),
		.f_reset     (f_reset),
		.dec         (dec),
		.ram_rdata   (ram_rdata),
		.sw          (sw),
		.pa_in       (pa_in),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.led         (led),
		.pa_out      (pa_out)
	);

endmodule

// File: tester_top.f
source/bus_pkg.sv
source/io_pkg.sv
source/bus_decoder.sv
source/sys_ram.sv
source/io_regs.sv
source/tester_top.sv
verification/tb_clock.sv
verification/tester_top_sva.sv
verification/tester_top_tb.sv

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic cpuclk,
	output logic f_reset
);

	localparam int half_period  = 5; // 10 ns clock
	localparam int reset_cycles = 8;

	initial begin
		cpuclk = 1'b0;
		forever #(half_period) cpuclk = ~cpuclk;
	end

	initial begin
		f_reset = 1'b1;
		repeat (reset_cycles) @(posedge cpuclk);
		#1 f_reset = 1'b0; // released like the other inputs
	end

endmodule

// File: verification/tester_top_sva.sv
`timescale 1ns/1ps

module tester_top_sva (
	input logic                     cpuclk,
	input logic                     f_reset,
	input bus_pkg::bus_req_t        req,
	input logic                     rdata_valid,
	input logic [io_pkg::led_w-1:0] led,
	input logic [io_pkg::pa_w-1:0]  pa_out
);

	// decoder stage plus register stage
	rd_gives_valid: assert property (@(posedge cpuclk) disable iff (f_reset)
		req.rd |-> ##2 rdata_valid)
		else $error("rdata_valid missing two cycles after a read request");

	no_rd_no_valid: assert property (@(posedge cpuclk) disable iff (f_reset)
		!req.rd |-> ##2 !rdata_valid)
		else $error("rdata_valid high without a read request two cycles before");

	rd_wr_exclusive: assert property (@(posedge cpuclk)
		!(req.rd && req.wr))
		else $error("request with rd and wr both high");

	outputs_cleared: assert property (@(posedge cpuclk)
		f_reset |=> (pa_out == '0 && led == '0))
		else $error("pa_out or led not zero after reset");

endmodule

bind tester_top tester_top_sva tester_top_sva_inst (
	.cpuclk      (cpuclk),
	.f_reset     (f_reset),
	.req         (req),
	.rdata_valid (rdata_valid),
	.led         (led),
	.pa_out      (pa_out)
);

// File: verification/tester_top_tb.sv
`timescale 1ns/1ps

module tester_top_tb;

	localparam int reset_cycles = 8;
	localparam int read_timeout = 8;
	// cycle estimate per test, in run order
	localparam int test_cycles  = 10 + 60 + 30 + 20 + 40 + 50;
	localparam int margin_ns    = 1000;
	localparam int watchdog_ns  = (reset_cycles + test_cycles) * 10 + margin_ns;

	logic                       cpuclk;
	logic                       f_reset;
	bus_pkg::bus_req_t          req;
	logic [io_pkg::sw_w-1:0]    sw;
	logic [io_pkg::pa_w-1:0]    pa_in;
	logic [bus_pkg::data_w-1:0] rdata;
	logic                       rdata_valid;
	logic [io_pkg::led_w-1:0]   led;
	logic [io_pkg::pa_w-1:0]    pa_out;

	int error_count;
	int tests_run;
	int tests_failed;

	tb_clock clock_inst (
		.cpuclk  (cpuclk),
		.f_reset (f_reset)
	);

	tester_top tester_top_inst (
		.cpuclk      (cpuclk),
		.f_reset     (f_reset),
		.req         (req),
		.sw          (sw),
		.pa_in       (pa_in),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.led         (led),
		.pa_out      (pa_out)
	);

	task automatic compare_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
			error_count++;
		end
	endtask

	// returns 1 ns after the last edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge cpuclk);
		#1;
	endtask

	task automatic write_byte(input logic [15:0] adr, input logic [7:0] data);
		req.adr   = adr;
		req.wdata = data;
		req.rd    = 1'b0;
		req.wr    = 1'b1;
		wait_cycles(1);
		req = '0;
	endtask

	task automatic read_byte(input logic [15:0] adr, output logic [7:0] data);
		int waited;
		req       = '0;
		req.adr   = adr;
		req.rd    = 1'b1;
		wait_cycles(1);
		req    = '0;
		waited = 0;
		do begin
			wait_cycles(1);
			waited++;
		end while (!rdata_valid && waited < read_timeout);
		data = rdata;
		if (!rdata_valid) begin
			$display("read of address %h got no rdata_valid within %0d cycles", adr, waited);
			error_count++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic test_reset_preload();
		int         errors_before;
		logic [7:0] data;
		errors_before = error_count;
		compare_value("led", 32'(led), 'h0);
		compare_value("pa_out", 32'(pa_out), 'h0);
		compare_value("rdata_valid", 32'(rdata_valid), 'h0);
		compare_value("rdata", 32'(rdata), 'hff);
		read_byte(16'h0000, data);
		compare_value("rdata", 32'(data), 'h18); // preloaded jump opcode
		read_byte(16'h0001, data);
		compare_value("rdata", 32'(data), 'hfe);
		end_test("reset and preload", errors_before);
	endtask

	task automatic test_sysram();
		int          errors_before;
		logic [15:0] adrs [8];
		logic [7:0]  vals [8];
		logic [7:0]  data;
		errors_before = error_count;
		for (int i = 0; i < 8; i++) begin
			adrs[i] = 16'(i * 512) + 16'($urandom_range(511, 2)); // one per 512-byte slice
			vals[i] = 8'($urandom);
			write_byte(adrs[i], vals[i]);
		end
		for (int i = 0; i < 8; i++) begin
			read_byte(adrs[i], data);
			compare_value("rdata", 32'(data), 32'(vals[i]));
		end
		// back to back, reverse order, data two cycles behind
		for (int k = 0; k < 10; k++) begin
			req = '0;
			if (k < 8) begin
				req.adr = adrs[7 - k];
				req.rd  = 1'b1;
			end
			if (k >= 2) begin
				compare_value("rdata_valid", 32'(rdata_valid), 'h1);
				compare_value("rdata", 32'(rdata), 32'(vals[9 - k]));
			end
			wait_cycles(1);
		end
		req = '0;
		end_test("system ram", errors_before);
	endtask

	task automatic test_led_sw();
		int         errors_before;
		logic [7:0] lo;
		logic [7:0] hi;
		logic [7:0] data;
		errors_before = error_count;
		lo = 8'($urandom);
		hi = 8'($urandom);
		write_byte(bus_pkg::led0_adr, lo);
		write_byte(bus_pkg::led1_adr, hi);
		wait_cycles(1);
		compare_value("led", 32'(led), 32'({hi, lo}));
		read_byte(bus_pkg::led0_adr, data);
		compare_value("rdata", 32'(data), 32'(lo));
		read_byte(bus_pkg::led1_adr, data);
		compare_value("rdata", 32'(data), 32'(hi));
		sw = 16'($urandom);
		read_byte(bus_pkg::sw0_adr, data);
		compare_value("rdata", 32'(data), 32'(sw[7:0]));
		read_byte(bus_pkg::sw1_adr, data);
		compare_value("rdata", 32'(data), 32'(sw[15:8]));
		read_byte(16'h8000, data); // nothing mapped here
		compare_value("rdata", 32'(data), 'hff);
		write_byte(bus_pkg::sw0_adr, ~sw[7:0]);
		read_byte(bus_pkg::sw0_adr, data);
		compare_value("rdata", 32'(data), 32'(sw[7:0]));
		compare_value("led", 32'(led), 32'({hi, lo}));
		end_test("leds, switches and unmapped reads", errors_before);
	endtask

	task automatic test_atom();
		int         errors_before;
		logic [7:0] bytes [4];
		logic [7:0] data;
		errors_before = error_count;
		for (int i = 0; i < 4; i++) begin
			bytes[i] = 8'($urandom);
			write_byte(bus_pkg::atom_base + 16'(i), bytes[i]);
		end
		for (int i = 0; i < 4; i++) begin
			read_byte(bus_pkg::atom_base + 16'(i), data);
			compare_value("rdata", 32'(data), 32'(bytes[i]));
		end
		end_test("atomic register", errors_before);
	endtask

	task automatic test_pa_masks();
		int         errors_before;
		logic [7:0] expect_pa;
		logic [7:0] mask;
		logic [7:0] ignored;
		logic [7:0] data;
		errors_before = error_count;
		mask = 8'($urandom);
		write_byte(bus_pkg::pa_base, mask);
		wait_cycles(1);
		compare_value("pa_out", 32'(pa_out), 'h0); // mask registered, output not yet
		wait_cycles(1);
		expect_pa = mask;
		compare_value("pa_out", 32'(pa_out), 32'(expect_pa));
		read_byte(bus_pkg::pa_base, data);
		compare_value("rdata", 32'(data), 32'(expect_pa));
		pa_in = 8'($urandom);
		read_byte(bus_pkg::pa_base + 16'd1, data);
		compare_value("rdata", 32'(data), 32'(pa_in));
		mask = 8'($urandom);
		write_byte(bus_pkg::pa_base + 16'd1, mask);
		wait_cycles(2);
		expect_pa = expect_pa & ~mask;
		compare_value("pa_out", 32'(pa_out), 32'(expect_pa));
		// second write right behind the first does not count
		mask    = 8'($urandom);
		ignored = ~(expect_pa | mask);
		write_byte(bus_pkg::pa_base, mask);
		write_byte(bus_pkg::pa_base, ignored);
		wait_cycles(2);
		expect_pa = expect_pa | mask;
		compare_value("pa_out", 32'(pa_out), 32'(expect_pa));
		write_byte(bus_pkg::pa_base + 16'd1, 8'hff);
		wait_cycles(2);
		compare_value("pa_out", 32'(pa_out), 'h0);
		end_test("port A masks", errors_before);
	endtask

	task automatic test_route_trigger();
		int         errors_before;
		logic [3:0] route_pat;
		errors_before = error_count;
		route_pat = 4'($urandom_range(15, 1));
		write_byte(bus_pkg::atom_base, {4'h0, route_pat});
		write_byte(bus_pkg::route_adr, 8'h00);
		// trigger with no route bit in common
		write_byte(bus_pkg::atom_base, {4'h0, ~route_pat});
		write_byte(bus_pkg::pa_base + 16'd2, 8'h01);
		wait_cycles(2);
		compare_value("pa_out[0]", 32'(pa_out[0]), 'h0);
		write_byte(bus_pkg::atom_base, {4'h0, route_pat});
		write_byte(bus_pkg::pa_base + 16'd2, 8'h01);
		wait_cycles(2);
		compare_value("pa_out[0]", 32'(pa_out[0]), 'h1);
		wait_cycles(5);
		compare_value("pa_out[0]", 32'(pa_out[0]), 'h1); // held by the route match
		write_byte(bus_pkg::pa_base + 16'd3, 8'h02); // not 1, no load
		wait_cycles(2);
		compare_value("pa_out[0]", 32'(pa_out[0]), 'h1);
		write_byte(bus_pkg::pa_base + 16'd3, 8'h01);
		wait_cycles(2);
		compare_value("pa_out[0]", 32'(pa_out[0]), 'h0);
		wait_cycles(3);
		compare_value("pa_out[0]", 32'(pa_out[0]), 'h0);
		end_test("routed trigger", errors_before);
	endtask

	initial begin
		req          = '0;
		sw           = '0;
		pa_in        = '0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(32'h48842a7d));
		wait (f_reset === 1'b1);
		wait (f_reset === 1'b0);
		wait_cycles(1);
		test_reset_preload();
		test_sysram();
		test_led_sw();
		test_atom();
		test_pa_masks();
		test_route_trigger();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("run timed out after %0d ns before all tests finished", watchdog_ns);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule
